//--- compile.f
design/pipeline_pkg.sv
design/mem_bus_pkg.sv
design/dmem_if.sv
design/mem_stage.sv
design/dmem_model.sv
design/writeback_stage.sv
design/mem_subsystem.sv
dv/mem_stage_checker.sv
dv/mem_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module mem_subsystem_tb \
  -Mdir obj_dir

./obj_dir/Vmem_subsystem_tb | tee sim.log

if grep -q "TEST PASS" sim.log; then
  exit 0
else
  exit 1
fi

//--- dv/mem_subsystem_tb.sv
/*
  Table driven testbench for the memory subsystem. One entry in flight
  at a time, with an idle cycle after each. Store data is random with a fixed seed.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
  import pipeline_pkg::*, mem_bus_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam logic [1:0] KIND_ALU   = 2'd0;
  localparam logic [1:0] KIND_LOAD  = 2'd1;
  localparam logic [1:0] KIND_STORE = 2'd2;

  typedef struct {
    logic [1:0]           kind;
    logic [XLEN-1:0]      addr;       // alu_result, also the address
    logic [XLEN-1:0]      data;       // rega_value
    logic [REG_IDX_W-1:0] dest_reg;
    logic                 halt;
    logic [XLEN-1:0]      expected;   // wb_result if it retires
  } stim_entry_t;

  logic clock, reset, in_valid, in_halt, in_illegal, in_take_branch;
  logic in_rd_mem, in_wr_mem;
  logic [XLEN-1:0] in_npc, in_alu_result, in_rega_value;
  logic [INST_W-1:0] in_inst;
  logic [REG_IDX_W-1:0] in_dest_reg, wb_dest_reg;
  logic stall, wb_valid, wb_take_branch, halted;
  logic [XLEN-1:0] wb_result, wb_npc;
  logic [RETIRE_CNT_W-1:0] retired_count;

  stim_entry_t     stim_table [$];
  logic [XLEN-1:0] ref_mem [MEM_WORDS];   // expected memory contents
  integer          seed = 32'ha494;
  int              error_count = 0;
  int              retired_exp = 0;
  logic            halted_exp = 1'b0;
  bit              table_built = 1'b0;

  mem_subsystem dut (.*);

  bind mem_stage mem_stage_checker u_mem_stage_checker (
    .clock (clock), .reset (reset), .command (dmem.command),
    .response (dmem.response), .tag (dmem.tag), .wait_tag (wait_tag)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  //////////////////////////////
  // table and checks
  //////////////////////////////
  task automatic add_entry(input logic [1:0] kind, input logic [XLEN-1:0] addr,
                           input logic [REG_IDX_W-1:0] dest, input logic halt);
    stim_entry_t e;
    logic [MEM_IDX_W-1:0] idx;
    idx = addr[MEM_ADDR_LSB +: MEM_IDX_W];   // bits above 10 alias
    e.kind = kind;
    e.addr = addr;
    e.dest_reg = dest;
    e.halt = halt;
    e.data = {$random(seed), $random(seed)};
    e.expected = (kind == KIND_LOAD) ? ref_mem[idx] : addr;
    if (kind == KIND_STORE) begin
      ref_mem[idx] = e.data;
    end
    stim_table.push_back(e);
  endtask

  task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp, input int entry);
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h at entry %0d", name, exp, got, entry);
    end
  endtask

  task automatic apply_entry(input int i);
    stim_entry_t e;
    int stall_cycles;
    e = stim_table[i];
    stall_cycles = 0;
    @(posedge clock);
    in_valid       <= 1'b1;
    in_npc         <= 64'h1000 + 64'(i * 4);
    in_halt        <= e.halt;
    in_take_branch <= (i % 2 == 1);   // odd entries branch
    in_dest_reg    <= e.dest_reg;
    in_rd_mem      <= (e.kind == KIND_LOAD);
    in_wr_mem      <= (e.kind == KIND_STORE);
    in_alu_result  <= e.addr;
    in_rega_value  <= e.data;
    @(negedge clock);
    // held until stall drops, bounded in case data never comes back
    while (stall && stall_cycles <= LOAD_LATENCY) begin
      stall_cycles++;
      @(negedge clock);
      compare_value("wb_valid", 64'(wb_valid), 64'd0, i);   // nothing under stall
    end
    compare_value("stall_cycles", 64'(stall_cycles),
                  (e.kind == KIND_LOAD) ? 64'(LOAD_LATENCY) : 64'd0, i);
    @(posedge clock);
    in_valid  <= 1'b0;   // idle gap
    in_halt   <= 1'b0;
    in_rd_mem <= 1'b0;
    in_wr_mem <= 1'b0;
    @(negedge clock);
    compare_value("wb_valid", 64'(wb_valid), 64'(!halted_exp), i);
    if (!halted_exp) begin
      compare_value("wb_result", wb_result, e.expected, i);
      compare_value("wb_dest_reg", 64'(wb_dest_reg), 64'(e.dest_reg), i);
      compare_value("wb_npc", wb_npc, 64'h1000 + 64'(i * 4), i);
      compare_value("wb_take_branch", 64'(wb_take_branch), 64'(i % 2), i);
      retired_exp++;
      halted_exp = e.halt;
    end
    compare_value("retired_count", 64'(retired_count), 64'(retired_exp), i);
    compare_value("halted", 64'(halted), 64'(halted_exp), i);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_npc = '0;
    in_inst = 32'h0000_0013;
    in_halt = 1'b0;
    in_illegal = 1'b0;
    in_take_branch = 1'b0;
    in_dest_reg = ZERO_REG;
    in_rd_mem = 1'b0;
    in_wr_mem = 1'b0;
    in_alu_result = '0;
    in_rega_value = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = '0;   // memory clears on reset
    end
    add_entry(KIND_ALU,   64'h0000_0000_dead_beef, 5'd3, 1'b0);
    add_entry(KIND_STORE, 64'h40, ZERO_REG, 1'b0);
    add_entry(KIND_LOAD,  64'h40, 5'd5, 1'b0);
    add_entry(KIND_LOAD,  64'h80, 5'd6, 1'b0);               // never written
    add_entry(KIND_STORE, 64'h88, ZERO_REG, 1'b0);
    add_entry(KIND_LOAD,  64'h888, 5'd7, 1'b0);              // bit 11 ignored
    add_entry(KIND_STORE, 64'hffff_0000_0000_07f8, ZERO_REG, 1'b0);
    add_entry(KIND_LOAD,  64'h7f8, 5'd8, 1'b0);
    add_entry(KIND_ALU,   64'h0123_4567_89ab_cdef, 5'd0, 1'b0);
    add_entry(KIND_LOAD,  64'h40, 5'd9, 1'b0);
    add_entry(KIND_ALU,   64'h1111, 5'd10, 1'b1);            // halt
    add_entry(KIND_ALU,   64'h2222, 5'd11, 1'b0);            // past halt
    add_entry(KIND_LOAD,  64'h88, 5'd12, 1'b0);
    table_built = 1'b1;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < stim_table.size(); i++) begin
      apply_entry(i);
    end
    repeat (3) @(negedge clock);
    compare_value("halted", 64'(halted), 64'(halted_exp), stim_table.size());
    compare_value("retired_count", 64'(retired_count), 64'(retired_exp), stim_table.size());
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog, sized from the table length
  initial begin
    wait (table_built);
    repeat (stim_table.size() * (LOAD_LATENCY + 3) + 20) @(posedge clock);
    $display("watchdog expired, the test did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/mem_stage_checker.sv
/*
  Bus protocol checks on the memory stage, attached by bind.
  Assumes one outstanding load and tag 0 meaning none.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker
  import mem_bus_pkg::*;
(
  input logic             clock,
  input logic             reset,
  input bus_command_e     command,
  input logic [TAG_W-1:0] response,
  input logic [TAG_W-1:0] tag,
  input logic [TAG_W-1:0] wait_tag   // stage's pending load tag
);

  //////////////////////////////
  // bus rules
  //////////////////////////////
  // bus stays idle from load issue until its data is back
  idle_while_waiting: assert property (
    @(posedge clock) disable iff (reset)
      (((command == bus_load) && (response != TAG_NONE)) ||
       ((wait_tag != TAG_NONE) && (tag == TAG_NONE))) |=> (command == bus_none)
  ) else $error("bus command %0d sent while a load is pending", command);

  // response only answers a command
  response_needs_command: assert property (
    @(posedge clock) disable iff (reset)
      (response != TAG_NONE) |-> (command != bus_none)
  ) else $error("response %h without a bus command", response);

  // returned data needs a load in flight
  tag_needs_outstanding: assert property (
    @(posedge clock) disable iff (reset)
      (tag != TAG_NONE) |-> (wait_tag != TAG_NONE)
  ) else $error("tag %h returned with no load outstanding", tag);

  //////////////////////////////
  // reset
  //////////////////////////////
  quiet_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> (command == bus_none)
  ) else $error("bus not idle right after reset");

endmodule

`default_nettype wire

//--- design/mem_subsystem.sv
/*
  Top level: memory stage, data memory and completion stage.
  Inputs must be held while stall is high.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
  import pipeline_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,

  // execute -> memory packet, flattened
  input  logic                    in_valid,
  input  logic [XLEN-1:0]         in_npc,
  input  logic [INST_W-1:0]       in_inst,
  input  logic                    in_halt,
  input  logic                    in_illegal,
  input  logic                    in_take_branch,
  input  logic [REG_IDX_W-1:0]    in_dest_reg,
  input  logic                    in_rd_mem,
  input  logic                    in_wr_mem,
  input  logic [XLEN-1:0]         in_alu_result,   // result or address
  input  logic [XLEN-1:0]         in_rega_value,   // store data

  output logic                    stall,
  output logic                    wb_valid,
  output logic [REG_IDX_W-1:0]    wb_dest_reg,
  output logic [XLEN-1:0]         wb_result,
  output logic [XLEN-1:0]         wb_npc,
  output logic                    wb_take_branch,
  output logic                    halted,
  output logic [RETIRE_CNT_W-1:0] retired_count
);

  x_c_packet_t x_c_packet;
  c_r_packet_t c_r_packet;

  assign x_c_packet = '{
    npc:          in_npc,
    inst:         in_inst,
    halt:         in_halt,
    illegal:      in_illegal,
    take_branch:  in_take_branch,
    dest_reg_idx: in_dest_reg,
    rd_mem:       in_rd_mem,
    wr_mem:       in_wr_mem,
    alu_result:   in_alu_result,
    rega_value:   in_rega_value,
    valid:        in_valid
  };

  assign stall = c_r_packet.stall;   // back-pressure to the source

  dmem_if dmem_bus ();

  mem_stage u_mem_stage (
    .clock         (clock),
    .reset         (reset),
    .x_c_packet_in (x_c_packet),
    .dmem          (dmem_bus.proc),
    .c_packet_out  (c_r_packet)
  );

  dmem_model u_dmem_model (
    .clock (clock),
    .reset (reset),
    .dmem  (dmem_bus.mem)
  );

  writeback_stage u_writeback_stage (
    .clock          (clock),
    .reset          (reset),
    .c_packet_in    (c_r_packet),
    .wb_valid       (wb_valid),
    .wb_dest_reg    (wb_dest_reg),
    .wb_result      (wb_result),
    .wb_npc         (wb_npc),
    .wb_take_branch (wb_take_branch),
    .halted         (halted),
    .retired_count  (retired_count)
  );

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
/*
  Completion register, one cycle behind the memory stage.
  After a halt or illegal packet retires, nothing retires until reset.
*/
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
  import pipeline_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  c_r_packet_t             c_packet_in,
  output logic                    wb_valid,
  output logic [REG_IDX_W-1:0]    wb_dest_reg,
  output logic [XLEN-1:0]         wb_result,
  output logic [XLEN-1:0]         wb_npc,
  output logic                    wb_take_branch,
  output logic                    halted,
  output logic [RETIRE_CNT_W-1:0] retired_count
);

  logic retire;
  logic stop_req;

  // valid is already masked by stall
  assign retire   = c_packet_in.valid && !halted;
  assign stop_req = c_packet_in.halt | c_packet_in.illegal;

  //////////////////////////////
  // control state
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid      <= 1'b0;
      halted        <= 1'b0;
      retired_count <= '0;
    end else begin
      wb_valid <= retire;
      if (retire) begin
        retired_count <= retired_count + RETIRE_CNT_W'(1);
        if (stop_req) begin
          halted <= 1'b1;   // sticky
        end
      end
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////
  // held between retirements
  always_ff @(posedge clock) begin
    if (retire) begin
      wb_dest_reg    <= c_packet_in.dest_reg_idx;
      wb_result      <= c_packet_in.result;
      wb_npc         <= c_packet_in.npc;
      wb_take_branch <= c_packet_in.take_branch;
    end
  end

endmodule

`default_nettype wire

//--- design/dmem_model.sv
/*
  Tagged data memory, 256 words of 64 bits, clears on reset.
  Loads return after LOAD_LATENCY cycles, one load outstanding at most.
  Address bits above 10 are ignored, so high addresses alias.
*/
`timescale 1ns/1ps
`default_nettype none

module dmem_model
  import pipeline_pkg::*, mem_bus_pkg::*;
(
  input  logic clock,
  input  logic reset,
  dmem_if.mem  dmem
);

  logic [XLEN-1:0]      mem_array [MEM_WORDS];
  logic [MEM_IDX_W-1:0] req_idx;
  logic                 accept;
  logic                 load_busy;
  logic                 load_arrive;

  // round-robin response source
  logic [TAG_W-1:0]     next_resp;

  // outstanding load
  logic [LAT_CNT_W-1:0] load_count;     // cycles left, 0 = idle
  logic [MEM_IDX_W-1:0] load_idx_q;
  logic [TAG_W-1:0]     load_tag_q;

  assign req_idx = dmem.addr[MEM_ADDR_LSB +: MEM_IDX_W];   // word index

  assign load_busy   = (load_count != '0);
  assign load_arrive = (load_count == LAT_CNT_W'(1));    // last cycle of the load

  // refuse everything while a load is in flight
  assign accept = (dmem.command != bus_none) && !load_busy;

  //////////////////////////////
  // response
  //////////////////////////////
  assign dmem.response = accept ? next_resp : TAG_NONE;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_resp <= TAG_FIRST;
    end else if (accept) begin
      // wrap 15 -> 1, never hand out 0
      next_resp <= (next_resp == TAG_LAST) ? TAG_FIRST : next_resp + TAG_W'(1);
    end
  end

  //////////////////////////////
  // word array
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_array[i] <= '0;
      end
    end else if (accept && (dmem.command == bus_store)) begin
      mem_array[req_idx] <= dmem.data;   // store lands at end of issue cycle
    end
  end

  //////////////////////////////
  // load tracking
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      load_count <= '0;
    end else if (accept && (dmem.command == bus_load)) begin
      load_count <= LAT_CNT_W'(LOAD_LATENCY);
    end else if (load_busy) begin
      load_count <= load_count - LAT_CNT_W'(1);
    end
  end

  // address and tag of the load in flight
  always_ff @(posedge clock) begin
    if (accept && (dmem.command == bus_load)) begin
      load_idx_q <= req_idx;
      load_tag_q <= next_resp;
    end
  end

  // data and tag valid for exactly one cycle
  assign dmem.tag   = load_arrive ? load_tag_q : TAG_NONE;
  assign dmem.rdata = load_arrive ? mem_array[load_idx_q] : '0;

endmodule

`default_nettype wire

//--- design/mem_stage.sv
/*
  Memory access stage. Combinational apart from the waiting tag.
  Source must hold its packet while stall is high.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_stage
  import pipeline_pkg::*, mem_bus_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  x_c_packet_t  x_c_packet_in,
  dmem_if.proc         dmem,
  output c_r_packet_t  c_packet_out
);

  logic [TAG_W-1:0] wait_tag;   // tag of the load in flight, 0 = none
  logic             rd_req;
  logic             wr_req;
  logic             load_done;
  logic             stall;
  logic             wait_tag_we;

  // only valid packets touch memory
  assign rd_req = x_c_packet_in.valid & x_c_packet_in.rd_mem;
  assign wr_req = x_c_packet_in.valid & x_c_packet_in.wr_mem;

  //////////////////////////////
  // bus request
  //////////////////////////////
  // nothing new goes out while a load is pending
  assign dmem.command = (wait_tag != TAG_NONE) ? bus_none  :
                        wr_req                 ? bus_store :
                        rd_req                 ? bus_load  :
                                                 bus_none;

  assign dmem.addr = x_c_packet_in.alu_result;   // address from the ALU
  assign dmem.data = x_c_packet_in.rega_value;

  //////////////////////////////
  // load return
  //////////////////////////////
  // returned tag must be live and ours
  assign load_done = rd_req && (dmem.tag != TAG_NONE) && (dmem.tag == wait_tag);

  // load not back yet, or store refused
  assign stall = (rd_req && !load_done) ||
                 (wr_req && (dmem.response == TAG_NONE));

  // latch on issue, clear on return (response is 0 then)
  assign wait_tag_we = rd_req && ((wait_tag == TAG_NONE) || load_done);

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_tag <= TAG_NONE;
    end else if (wait_tag_we) begin
      wait_tag <= dmem.response;
    end
  end

  //////////////////////////////
  // completion packet
  //////////////////////////////
  assign c_packet_out.npc         = x_c_packet_in.npc;
  assign c_packet_out.inst        = x_c_packet_in.inst;
  assign c_packet_out.halt        = x_c_packet_in.halt;
  assign c_packet_out.illegal     = x_c_packet_in.illegal;
  assign c_packet_out.take_branch = x_c_packet_in.take_branch;

  // a stalled packet must not write anything
  assign c_packet_out.dest_reg_idx = stall ? ZERO_REG : x_c_packet_in.dest_reg_idx;
  assign c_packet_out.valid        = x_c_packet_in.valid & ~stall;

  assign c_packet_out.result = load_done ? dmem.rdata            // load data
                                         : x_c_packet_in.alu_result;
  assign c_packet_out.stall  = stall;

endmodule

`default_nettype wire

//--- design/dmem_if.sv
/*
  Processor to data-memory bus. response is combinational in the issue
  cycle, tag/rdata are valid together for exactly one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

interface dmem_if
  import pipeline_pkg::*, mem_bus_pkg::*;
();

  // processor side
  bus_command_e     command;
  logic [XLEN-1:0]  addr;       // byte address
  logic [XLEN-1:0]  data;       // store data

  // memory side
  logic [TAG_W-1:0] response;   // nonzero = accepted, value is the tag
  logic [TAG_W-1:0] tag;        // nonzero with rdata
  logic [XLEN-1:0]  rdata;

  modport proc (output command, addr, data, input response, tag, rdata);
  modport mem  (input command, addr, data, output response, tag, rdata);

endinterface

`default_nettype wire

//--- design/mem_bus_pkg.sv
/*
  Data-memory bus encodings and memory sizing.
  One outstanding load only, whole 64-bit words, tag 0 means no tag.
*/
`default_nettype none

package mem_bus_pkg;

  // bus command codes
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_command_e;

  //////////////////////////////
  // tags
  //////////////////////////////
  localparam int TAG_W = 4;
  localparam logic [TAG_W-1:0] TAG_NONE  = '0;
  localparam logic [TAG_W-1:0] TAG_FIRST = 4'd1;   // 0 is skipped
  localparam logic [TAG_W-1:0] TAG_LAST  = 4'd15;

  //////////////////////////////
  // memory array
  //////////////////////////////
  localparam int MEM_WORDS    = 256;
  localparam int MEM_ADDR_LSB = 3;                    // byte offset in a word
  localparam int MEM_IDX_W    = $clog2(MEM_WORDS);    // addr bits 3..10

  // load timing
  localparam int LOAD_LATENCY = 3;                    // issue to data, cycles
  localparam int LAT_CNT_W    = $clog2(LOAD_LATENCY + 1);

endpackage

`default_nettype wire

//--- design/pipeline_pkg.sv
/*
  Packet types and widths shared by the memory and completion stages.
  Register index ZERO_REG marks a packet that writes no register.
*/
`default_nettype none

package pipeline_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int XLEN          = 64;   // data and address width
  localparam int INST_W        = 32;   // raw instruction word
  localparam int REG_IDX_W     = 5;
  localparam int RETIRE_CNT_W  = 32;   // retired instruction counter

  localparam logic [REG_IDX_W-1:0] ZERO_REG = 5'd31;  // no write

  //////////////////////////////
  // execute -> memory
  //////////////////////////////
  typedef struct packed {
    logic [XLEN-1:0]      npc;
    logic [INST_W-1:0]    inst;
    logic                 halt;
    logic                 illegal;
    logic                 take_branch;
    logic [REG_IDX_W-1:0] dest_reg_idx;
    logic                 rd_mem;       // load
    logic                 wr_mem;       // store
    logic [XLEN-1:0]      alu_result;   // also the memory address
    logic [XLEN-1:0]      rega_value;   // store data
    logic                 valid;
  } x_c_packet_t;

  //////////////////////////////
  // memory -> completion
  //////////////////////////////
  typedef struct packed {
    logic [XLEN-1:0]      npc;
    logic [INST_W-1:0]    inst;
    logic                 halt;
    logic                 illegal;
    logic                 take_branch;
    logic [REG_IDX_W-1:0] dest_reg_idx;
    logic [XLEN-1:0]      result;
    logic                 valid;        // already masked by stall
    logic                 stall;
  } c_r_packet_t;

endpackage

`default_nettype wire
